// File: logic/rename_cfg.svh
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// micro-ops renamed per cycle
`define RENAME_WIDTH 2

`define ARCH_REGS 32
`define PHYS_REGS 64

`define AREG_W 5 // log2 of ARCH_REGS
`define PREG_W 6 // log2 of PHYS_REGS

// registers not holding an architectural value after reset
`define FREE_DEPTH 32
`define FREE_W 5 // ring index width without the extra wrap bit of the pointers

`define ROB_DEPTH 32
`define ROB_W 5

// holds 0 up to RENAME_WIDTH
`define CNT_W 2

`endif

// File: logic/rename_pkg.sv
`include "rename_cfg.svh"

package rename_pkg;

    typedef enum logic [1:0] {
        UOP_ALU,
        UOP_LOAD,
        UOP_STORE,
        UOP_BRANCH
    } uop_kind_t;

    typedef enum logic {
        ST_RUN,
        ST_RECOVER
    } rename_state_t;

    typedef logic [`PREG_W-1:0] preg_t;
    typedef logic [`AREG_W-1:0] areg_t;
    typedef preg_t [`RENAME_WIDTH-1:0] preg_vec_t;

    typedef struct packed {
        logic             dir; // flips each time the index wraps
        logic [`ROB_W-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        logic      valid;
        logic      we;
        uop_kind_t kind;
        areg_t     rs1;
        areg_t     rs2;
        areg_t     rd;
    } dec_uop_t;

    typedef dec_uop_t [`RENAME_WIDTH-1:0] dec_group_t;

    typedef struct packed {
        logic      valid;
        logic      wen;
        uop_kind_t kind;
        preg_t     prs1;
        preg_t     prs2;
        preg_t     prd;
        preg_t     old_prd;
        rob_idx_t  rob;
    } ren_uop_t;

    typedef ren_uop_t [`RENAME_WIDTH-1:0] ren_group_t;

    typedef struct packed {
        logic  valid;
        logic  wen;
        areg_t vrd;
        preg_t prd;
        preg_t old_prd; // goes back to the free list
    } commit_t;

    typedef commit_t [`RENAME_WIDTH-1:0] commit_group_t;

    typedef struct packed {
        preg_t prs1;
        preg_t prs2;
        preg_t prd_cur;
    } map_slot_t;

    typedef map_slot_t [`RENAME_WIDTH-1:0] map_read_t;

    typedef struct packed {
        preg_vec_t prs1;
        preg_vec_t prs2;
    } src_sel_t;

    typedef struct packed {
        preg_vec_t prd;
        preg_vec_t old_prd;
    } dst_sel_t;

endpackage

// File: logic/rename_map_table.sv
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_map_table (
    input  logic                      clk,
    input  logic                      rst,
    input  rename_pkg::dec_group_t    dec_group,
    output rename_pkg::map_read_t     map_read,
    input  logic [`RENAME_WIDTH-1:0]  map_we,
    input  rename_pkg::preg_vec_t     alloc_prd,
    input  rename_pkg::commit_group_t commit,
    input  logic                      restore
);

    rename_pkg::preg_t spec_map  [`ARCH_REGS];
    rename_pkg::preg_t arch_map  [`ARCH_REGS];
    rename_pkg::preg_t arch_next [`ARCH_REGS];

    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            map_read[i].prs1    = spec_map[dec_group[i].rs1];
            map_read[i].prs2    = spec_map[dec_group[i].rs2];
            map_read[i].prd_cur = spec_map[dec_group[i].rd];
        end
    end

    // later commit slots overwrite earlier ones to the same register
    always_comb begin
        arch_next = arch_map;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (commit[i].valid && commit[i].wen) begin
                arch_next[commit[i].vrd] = commit[i].prd;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `ARCH_REGS; r++) begin
                spec_map[r] <= rename_pkg::preg_t'(r);
                arch_map[r] <= rename_pkg::preg_t'(r);
            end
        end else begin
            arch_map <= arch_next;
            if (restore) begin
                spec_map <= arch_next; // includes a commit landing on the same edge
            end else begin
                for (int i = 0; i < `RENAME_WIDTH; i++) begin
                    if (map_we[i]) begin
                        spec_map[dec_group[i].rd] <= alloc_prd[i];
                    end
                end
            end
        end
    end

endmodule

// File: logic/free_list.sv
`timescale 1ns/1ps
`include "rename_cfg.svh"

module free_list (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`CNT_W-1:0]         alloc_num,
    input  logic                      alloc_fire,
    output rename_pkg::preg_vec_t     alloc_prd,
    output logic [`FREE_W:0]          free_count,
    input  rename_pkg::commit_group_t commit,
    input  logic                      restore
);

    rename_pkg::preg_t ring [`FREE_DEPTH];

    logic [`FREE_W:0]         spec_head;
    logic [`FREE_W:0]         commit_head;
    logic [`FREE_W:0]         tail;
    logic [`FREE_W:0]         commit_head_next;
    logic [`RENAME_WIDTH-1:0] push_en;
    logic [`CNT_W-1:0]        push_rank [`RENAME_WIDTH];
    logic [`CNT_W-1:0]        push_num;

    // the stage picks from this window of the next entries by writer rank
    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            alloc_prd[i] = ring[spec_head[`FREE_W-1:0] + `FREE_W'(i)];
        end
    end

    assign free_count = tail - spec_head;

    always_comb begin
        push_num = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            push_en[i]   = commit[i].valid && commit[i].wen;
            push_rank[i] = push_num;
            push_num     = push_num + `CNT_W'(push_en[i]);
        end
        commit_head_next = commit_head + (`FREE_W+1)'(push_num);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < `FREE_DEPTH; k++) begin
                ring[k] <= rename_pkg::preg_t'(`ARCH_REGS + k);
            end
            spec_head   <= '0;
            commit_head <= '0;
            tail        <= (`FREE_W+1)'(`FREE_DEPTH); // ring starts full
        end else begin
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                if (push_en[i]) begin
                    ring[tail[`FREE_W-1:0] + `FREE_W'(push_rank[i])] <= commit[i].old_prd;
                end
            end
            tail        <= tail + (`FREE_W+1)'(push_num);
            commit_head <= commit_head_next;
            if (restore) begin
                // everything allocated past the committed point comes back
                spec_head <= commit_head_next;
            end else if (alloc_fire) begin
                spec_head <= spec_head + (`FREE_W+1)'(alloc_num);
            end
        end
    end

endmodule

// File: logic/dep_check.sv
`timescale 1ns/1ps
`include "rename_cfg.svh"

module dep_check (
    input  rename_pkg::dec_group_t   dec_group,
    input  rename_pkg::map_read_t    map_read,
    input  rename_pkg::preg_vec_t    alloc_prd,
    output rename_pkg::src_sel_t     ren_src,
    output rename_pkg::dst_sel_t     ren_dst,
    output logic [`RENAME_WIDTH-1:0] map_we,
    output logic [`CNT_W-1:0]        alloc_num
);

    logic [`RENAME_WIDTH-1:0] rd_en;
    logic [`CNT_W-1:0]        rank [`RENAME_WIDTH];
    rename_pkg::preg_vec_t    slot_prd;

    always_comb begin
        alloc_num = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            rd_en[i]  = dec_group[i].valid && dec_group[i].we;
            rank[i]   = alloc_num; // writers before this slot
            alloc_num = alloc_num + `CNT_W'(rd_en[i]);
        end
    end

    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            slot_prd[i] = rd_en[i] ? alloc_prd[rank[i]] : '0;
        end
    end

    // scanning older slots upward leaves the youngest match in place
    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            ren_src.prs1[i]    = map_read[i].prs1;
            ren_src.prs2[i]    = map_read[i].prs2;
            ren_dst.prd[i]     = slot_prd[i];
            ren_dst.old_prd[i] = map_read[i].prd_cur;
            for (int j = 0; j < i; j++) begin
                if (rd_en[j] && dec_group[j].rd == dec_group[i].rs1) begin
                    ren_src.prs1[i] = slot_prd[j];
                end
                if (rd_en[j] && dec_group[j].rd == dec_group[i].rs2) begin
                    ren_src.prs2[i] = slot_prd[j];
                end
                if (rd_en[j] && dec_group[j].rd == dec_group[i].rd) begin
                    ren_dst.old_prd[i] = slot_prd[j];
                end
            end
        end
    end

    // only the last writer of a register updates the table
    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            map_we[i] = rd_en[i];
            for (int j = i + 1; j < `RENAME_WIDTH; j++) begin
                if (rd_en[j] && dec_group[j].rd == dec_group[i].rd) begin
                    map_we[i] = 1'b0;
                end
            end
        end
    end

endmodule

// File: logic/rename_ctrl.sv
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  rename_pkg::dec_group_t   dec_group,
    input  logic                     dec_valid,
    output logic                     dec_ready,
    input  rename_pkg::src_sel_t     ren_src,
    input  rename_pkg::dst_sel_t     ren_dst,
    input  logic [`CNT_W-1:0]        alloc_num,
    input  logic [`FREE_W:0]         free_count,
    input  rename_pkg::rob_idx_t     rob_tail,
    output logic [`CNT_W-1:0]        rob_count,
    input  logic                     redirect,
    input  logic                     dis_ready,
    output logic                     alloc_fire,
    input  logic [`RENAME_WIDTH-1:0] map_we_in,
    output logic [`RENAME_WIDTH-1:0] map_we_fire,
    output logic                     restore,
    output rename_pkg::ren_group_t   ren_group,
    output logic                     ren_valid
);

    rename_pkg::rename_state_t state;
    rename_pkg::ren_group_t    next_group;

    logic              accept;
    logic              out_free;
    logic [`CNT_W-1:0] valid_num;
    logic [`ROB_W:0]   rob_sum [`RENAME_WIDTH];

    assign out_free  = !ren_valid || dis_ready;
    assign dec_ready = (state == rename_pkg::ST_RUN) && !redirect && out_free
                     && (free_count >= (`FREE_W+1)'(alloc_num));
    assign accept    = dec_valid && dec_ready;

    assign alloc_fire  = accept;
    assign map_we_fire = map_we_in & {`RENAME_WIDTH{accept}};
    assign restore     = redirect;
    assign rob_count   = accept ? valid_num : '0;

    // each valid micro-op takes the ROB slot after the ones before it
    always_comb begin
        valid_num = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            rob_sum[i] = {1'b0, rob_tail.idx} + (`ROB_W+1)'(valid_num);
            next_group[i].valid   = dec_group[i].valid;
            next_group[i].wen     = dec_group[i].valid && dec_group[i].we;
            next_group[i].kind    = dec_group[i].kind;
            next_group[i].prs1    = ren_src.prs1[i];
            next_group[i].prs2    = ren_src.prs2[i];
            next_group[i].prd     = ren_dst.prd[i];
            next_group[i].old_prd = ren_dst.old_prd[i];
            next_group[i].rob.idx = rob_sum[i][`ROB_W-1:0];
            next_group[i].rob.dir = rob_tail.dir ^ rob_sum[i][`ROB_W]; // a carry out of idx is a wrap
            valid_num = valid_num + `CNT_W'(dec_group[i].valid);
        end
    end

    // recover lasts one cycle after reset and after every redirect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= rename_pkg::ST_RECOVER;
            ren_valid <= 1'b0;
        end else begin
            state <= redirect ? rename_pkg::ST_RECOVER : rename_pkg::ST_RUN;
            if (redirect) begin
                ren_valid <= 1'b0;
            end else if (out_free) begin
                ren_valid <= accept;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ren_group <= next_group;
        end
    end

endmodule

// File: logic/rename_top.sv
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_top (
    input  logic                      clk,
    input  logic                      rst,
    input  rename_pkg::dec_group_t    dec_group,
    input  logic                      dec_valid,
    output logic                      dec_ready,
    output rename_pkg::ren_group_t    ren_group,
    output logic                      ren_valid,
    input  logic                      dis_ready,
    input  rename_pkg::rob_idx_t      rob_tail,
    output logic [`CNT_W-1:0]         rob_count,
    input  rename_pkg::commit_group_t commit,
    input  logic                      redirect
);

    rename_pkg::map_read_t    map_read;
    rename_pkg::preg_vec_t    alloc_prd;
    rename_pkg::src_sel_t     ren_src;
    rename_pkg::dst_sel_t     ren_dst;
    logic [`RENAME_WIDTH-1:0] map_we;
    logic [`RENAME_WIDTH-1:0] map_we_fire;
    logic [`CNT_W-1:0]        alloc_num;
    logic [`FREE_W:0]         free_count;
    logic                     alloc_fire;
    logic                     restore;

    rename_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .dec_group  (dec_group),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready),
        .ren_src    (ren_src),
        .ren_dst    (ren_dst),
        .alloc_num  (alloc_num),
        .free_count (free_count),
        .rob_tail   (rob_tail),
        .rob_count  (rob_count),
        .redirect   (redirect),
        .dis_ready  (dis_ready),
        .alloc_fire (alloc_fire),
        .map_we_in  (map_we),
        .map_we_fire(map_we_fire),
        .restore    (restore),
        .ren_group  (ren_group),
        .ren_valid  (ren_valid)
    );

    // the table is written with the per-slot prd, not the raw free-list window
    rename_map_table u_map (
        .clk       (clk),
        .rst       (rst),
        .dec_group (dec_group),
        .map_read  (map_read),
        .map_we    (map_we_fire),
        .alloc_prd (ren_dst.prd),
        .commit    (commit),
        .restore   (restore)
    );

    free_list u_free (
        .clk        (clk),
        .rst        (rst),
        .alloc_num  (alloc_num),
        .alloc_fire (alloc_fire),
        .alloc_prd  (alloc_prd),
        .free_count (free_count),
        .commit     (commit),
        .restore    (restore)
    );

    dep_check u_dep (
        .dec_group (dec_group),
        .map_read  (map_read),
        .alloc_prd (alloc_prd),
        .ren_src   (ren_src),
        .ren_dst   (ren_dst),
        .map_we    (map_we),
        .alloc_num (alloc_num)
    );

endmodule

// File: verification/rename_tb.sv
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_tb;

    // about sixty groups with a few stalls each and a wide margin on top
    localparam int CYCLE_LIMIT = 2000;

    logic                      clk;
    logic                      rst;
    rename_pkg::dec_group_t    dec_group;
    logic                      dec_valid;
    logic                      dec_ready;
    rename_pkg::ren_group_t    ren_group;
    logic                      ren_valid;
    logic                      dis_ready;
    rename_pkg::rob_idx_t      rob_tail;
    logic [`CNT_W-1:0]         rob_count;
    rename_pkg::commit_group_t commit;
    logic                      redirect;

    rename_pkg::preg_t      m_spec [`ARCH_REGS];
    rename_pkg::preg_t      m_arch [`ARCH_REGS];
    rename_pkg::preg_t      m_ring [`FREE_DEPTH];
    rename_pkg::commit_t    pending [$]; // accepted writers in program order
    rename_pkg::ren_group_t exp_group;
    logic                   exp_valid;
    logic                   exp_ready;
    logic [`CNT_W-1:0]      exp_rob_count;
    logic                   m_run;
    int                     m_shead;
    int                     m_chead;
    int                     m_tail;
    int                     m_rob; // dir and index together as one count modulo twice the depth
    int                     cycles;
    int                     errors;
    int                     errors_at_start;
    int                     tests;
    int                     clean;
    integer                 seed;

    rename_top DUT (
        .clk       (clk),
        .rst       (rst),
        .dec_group (dec_group),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .ren_group (ren_group),
        .ren_valid (ren_valid),
        .dis_ready (dis_ready),
        .rob_tail  (rob_tail),
        .rob_count (rob_count),
        .commit    (commit),
        .redirect  (redirect)
    );

    function automatic int count_writers(input rename_pkg::dec_group_t g);
        int n;
        n = 0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (g[i].valid && g[i].we) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic logic [`CNT_W-1:0] count_valid(input rename_pkg::dec_group_t g);
        int n;
        n = 0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (g[i].valid) begin
                n++;
            end
        end
        return `CNT_W'(n);
    endfunction

    // fields that carry no meaning for a slot are cleared before comparing
    function automatic rename_pkg::ren_group_t mask_group(input rename_pkg::ren_group_t g);
        rename_pkg::ren_group_t r;
        r = g;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (!g[i].valid) begin
                r[i] = '0;
            end else if (!g[i].wen) begin
                r[i].prd     = '0;
                r[i].old_prd = '0;
            end
        end
        return r;
    endfunction

    function automatic rename_pkg::dec_uop_t make_uop(input logic v, input logic w,
                                                      input int rs1, input int rs2, input int rd);
        rename_pkg::dec_uop_t u;
        u.valid = v;
        u.we    = w;
        u.kind  = rename_pkg::UOP_ALU;
        u.rs1   = `AREG_W'(rs1);
        u.rs2   = `AREG_W'(rs2);
        u.rd    = `AREG_W'(rd);
        return u;
    endfunction

    function automatic rename_pkg::dec_group_t rand_group();
        rename_pkg::dec_group_t g;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            g[i].valid = ($random(seed) & 3) != 0;
            g[i].we    = ($random(seed) & 3) != 0;
            g[i].kind  = rename_pkg::uop_kind_t'(2'($random(seed)));
            g[i].rs1   = `AREG_W'($random(seed) & 7); // small range makes same-group hits likely
            g[i].rs2   = `AREG_W'($random(seed));
            g[i].rd    = `AREG_W'($random(seed) & 7);
        end
        return g;
    endfunction

    // expected renaming of a group against the current model state
    function automatic rename_pkg::ren_group_t rename_model(input rename_pkg::dec_group_t g);
        rename_pkg::ren_group_t r;
        rename_pkg::preg_t      prd [`RENAME_WIDTH];
        logic                   wr  [`RENAME_WIDTH];
        int                     taken;
        int                     slots;
        int                     pos;
        taken = 0;
        slots = 0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            wr[i]  = g[i].valid && g[i].we;
            prd[i] = '0;
            if (wr[i]) begin
                prd[i] = m_ring[(m_shead + taken) % `FREE_DEPTH];
                taken++;
            end
            r[i].valid   = g[i].valid;
            r[i].wen     = wr[i];
            r[i].kind    = g[i].kind;
            r[i].prd     = prd[i];
            r[i].prs1    = m_spec[g[i].rs1];
            r[i].prs2    = m_spec[g[i].rs2];
            r[i].old_prd = m_spec[g[i].rd];
            for (int j = 0; j < i; j++) begin
                if (wr[j] && g[j].rd == g[i].rs1) begin
                    r[i].prs1 = prd[j];
                end
                if (wr[j] && g[j].rd == g[i].rs2) begin
                    r[i].prs2 = prd[j];
                end
                if (wr[j] && g[j].rd == g[i].rd) begin
                    r[i].old_prd = prd[j];
                end
            end
            pos = (m_rob + slots) % (2 * `ROB_DEPTH);
            r[i].rob.idx = `ROB_W'(pos % `ROB_DEPTH);
            r[i].rob.dir = pos >= `ROB_DEPTH;
            if (g[i].valid) begin
                slots++;
            end
        end
        return r;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        repeat (2) @(posedge clk);
        #1;
        tests++;
        if (errors == errors_at_start) begin
            clean++;
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // dec_ready is settled at the falling edge, so that is where the handshake is judged
    task automatic send_group(input rename_pkg::dec_group_t g);
        logic taken;
        taken     = 1'b0;
        dec_group = g;
        dec_valid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = dec_ready;
            @(posedge clk);
            #1;
        end
        dec_valid = 1'b0;
    endtask

    task automatic commit_pending(input int n_cycles);
        repeat (n_cycles) begin
            commit = '0;
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                if (pending.size() > 0) begin
                    commit[i] = pending.pop_front();
                end
            end
            @(posedge clk);
            #1;
        end
        commit = '0;
    endtask

    task automatic pulse_redirect();
        redirect = 1'b1;
        @(posedge clk);
        #1;
        redirect = 1'b0;
    endtask

    assign exp_ready = m_run && !redirect && (!exp_valid || dis_ready)
                     && (m_tail - m_shead >= count_writers(dec_group));
    assign exp_rob_count = (dec_valid && exp_ready) ? count_valid(dec_group) : '0;

    // reference model of both tables, the free-list ring and the output register
    always @(posedge clk or posedge rst) begin
        rename_pkg::ren_group_t r;
        rename_pkg::commit_t    c;
        logic                   acc;
        if (rst) begin
            for (int a = 0; a < `ARCH_REGS; a++) begin
                m_spec[a] = `PREG_W'(a);
                m_arch[a] = `PREG_W'(a);
            end
            for (int k = 0; k < `FREE_DEPTH; k++) begin
                m_ring[k] = `PREG_W'(`ARCH_REGS + k);
            end
            m_shead   = 0;
            m_chead   = 0;
            m_tail    = `FREE_DEPTH;
            m_rob     = 29; // close to the end so a group straddles the wrap early
            m_run     = 1'b0;
            exp_valid = 1'b0;
            pending.delete();
        end else begin
            acc = dec_valid && exp_ready;
            r   = rename_model(dec_group);
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                if (commit[i].valid && commit[i].wen) begin
                    m_arch[commit[i].vrd]       = commit[i].prd;
                    m_ring[m_tail % `FREE_DEPTH] = commit[i].old_prd;
                    m_tail++;
                    m_chead++;
                end
            end
            if (redirect) begin
                m_spec    = m_arch;
                m_shead   = m_chead;
                exp_valid = 1'b0;
                pending.delete();
            end else if (!exp_valid || dis_ready) begin
                exp_valid = acc;
            end
            if (acc) begin
                exp_group = r;
                for (int i = 0; i < `RENAME_WIDTH; i++) begin
                    if (r[i].wen) begin
                        m_spec[dec_group[i].rd] = r[i].prd;
                        c.valid   = 1'b1;
                        c.wen     = 1'b1;
                        c.vrd     = dec_group[i].rd;
                        c.prd     = r[i].prd;
                        c.old_prd = r[i].old_prd;
                        pending.push_back(c);
                        m_shead++;
                    end
                end
                m_rob = (m_rob + int'(count_valid(dec_group))) % (2 * `ROB_DEPTH);
            end
            m_run = !redirect;
        end
    end

    assert property (@(posedge clk) disable iff (rst) dec_ready == exp_ready)
        else flag_error("dec_ready differs from the model");
    assert property (@(posedge clk) disable iff (rst) ren_valid == exp_valid)
        else flag_error("ren_valid differs from the model");
    assert property (@(posedge clk) disable iff (rst)
        ren_valid |-> (mask_group(ren_group) == mask_group(exp_group)))
        else flag_error("renamed group differs from the model");
    assert property (@(posedge clk) disable iff (rst) rob_count == exp_rob_count)
        else flag_error("rob_count differs from the model");
    assert property (@(posedge clk) disable iff (rst)
        (ren_valid && !dis_ready && !redirect) |=> (ren_valid && $stable(ren_group)))
        else flag_error("output changed while dispatch held it");

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        rob_tail = {m_rob >= `ROB_DEPTH, `ROB_W'(m_rob % `ROB_DEPTH)};
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, a handshake never completed", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        rename_pkg::dec_group_t g;
        seed            = 50742;
        cycles          = 0;
        errors          = 0;
        errors_at_start = 0;
        tests           = 0;
        clean           = 0;
        rst             = 1'b1;
        dec_group       = '0;
        dec_valid       = 1'b0;
        dis_ready       = 1'b1;
        rob_tail        = {1'b0, 5'd29};
        commit          = '0;
        redirect        = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        send_group({make_uop(1, 1, 5, 6, 4), make_uop(1, 1, 2, 3, 1)});
        send_group({make_uop(1, 1, 9, 10, 11), make_uop(1, 0, 7, 8, 0)});
        end_test("reset and first allocation");

        send_group({make_uop(1, 1, 7, 7, 8), make_uop(1, 1, 1, 2, 7)});
        end_test("same-group read-after-write");

        send_group({make_uop(1, 1, 9, 3, 9), make_uop(1, 1, 4, 5, 9)});
        send_group({make_uop(1, 1, 9, 9, 12), make_uop(1, 0, 9, 1, 0)});
        for (int n = 0; n < 8; n++) begin
            send_group(rand_group());
        end
        commit_pending(4);
        end_test("same-group write-after-write and random groups");

        dis_ready = 1'b0;
        fork
            begin
                send_group({make_uop(1, 1, 1, 2, 3), make_uop(1, 1, 3, 4, 5)});
                send_group({make_uop(1, 1, 5, 6, 7), make_uop(1, 0, 7, 8, 0)});
            end
            begin
                repeat (5) @(posedge clk);
                #1;
                dis_ready = 1'b1;
            end
        join
        g = {make_uop(1, 1, 14, 15, 13), make_uop(1, 1, 16, 17, 14)};
        while (m_tail - m_shead >= 2) begin
            send_group(g);
        end
        fork
            send_group(g);
            begin
                repeat (4) @(posedge clk);
                #1;
                commit_pending(1);
            end
        join
        end_test("back-pressure and free-list exhaustion");

        commit_pending(8);
        for (int n = 0; n < 12; n++) begin
            send_group({make_uop(n % 3 != 1, 0, n, 1, 0), make_uop(n % 3 != 2, n % 2, 2, n, 20)});
        end
        end_test("ROB indices and wrap");

        commit_pending(3);
        send_group({make_uop(1, 1, 1, 2, 2), make_uop(1, 1, 3, 4, 1)});
        dis_ready = 1'b0; // dispatch holds the last group so only the flush can drop it
        pulse_redirect();
        dis_ready = 1'b1;
        send_group({make_uop(1, 1, 1, 1, 6), make_uop(1, 1, 2, 6, 5)});
        send_group(rand_group());
        commit_pending(2);
        end_test("redirect");

        $display("%0d of %0d tests clean, %0d errors in total", clean, tests, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+logic
logic/rename_pkg.sv
logic/rename_map_table.sv
logic/free_list.sv
logic/dep_check.sv
logic/rename_ctrl.sv
logic/rename_top.sv
verification/rename_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= rename_tb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FILELIST) logic/rename_cfg.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^TESTS PASSED$$' $(LOG) || { echo "no pass line found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
